// ==== all.f ====
logic/mem_pkg.sv
logic/mem_bus_if.sv
logic/mem_access_stage.sv
logic/data_memory.sv
logic/mem_subsystem_top.sv
verification/mem_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the memory-access stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f all.f \
    --top-module mem_subsystem_tb -o mem_subsystem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_subsystem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0

// ==== verification/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb import mem_pkg::*; ();

    localparam int DEPTH_WORDS    = 256;
    localparam int READ_LATENCY   = 2;
    localparam int BUSY_CYCLES    = 1;
    localparam int RESET_CYCLES   = 10;
    localparam int N_PASS         = 40;
    localparam int N_WORD         = 60;
    localparam int N_SUB          = 80;
    localparam int N_B2B          = 60;
    // Each flush round is a store, a flushed store and a load
    localparam int N_FLUSH        = 8;
    localparam int N_TOTAL        = N_PASS + N_WORD + N_SUB + N_B2B + 3 * N_FLUSH;
    localparam int TIMEOUT_CYCLES = N_TOTAL * (READ_LATENCY + BUSY_CYCLES + 3) + RESET_CYCLES;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        word_t     rs2_data;
        word_t     alu_out;
        logic      br_flg;
        word_t     br_target;
        mem_op_e   op;
        logic      rf_wen;
        wb_sel_t   wb_sel;
        reg_addr_t wb_addr;
        logic      jmp_flg;
        word_t     read_data;
        int        issue_cycle;
    } instr_t;

    logic      clk;
    logic      reset;
    logic      flush;
    word_t     in_pc;
    word_t     in_inst;
    word_t     in_rs2_data;
    word_t     in_alu_out;
    logic      in_br_flg;
    word_t     in_br_target;
    mem_op_e   in_mem_op;
    logic      in_rf_wen;
    wb_sel_t   in_wb_sel;
    reg_addr_t in_wb_addr;
    logic      in_jmp_flg;
    word_t     out_read_data;
    word_t     out_pc;
    word_t     out_inst;
    word_t     out_alu_out;
    logic      out_br_flg;
    word_t     out_br_target;
    logic      out_rf_wen;
    wb_sel_t   out_wb_sel;
    reg_addr_t out_wb_addr;
    logic      out_jmp_flg;
    logic      stall;
    logic      fwd_rf_wen;
    reg_addr_t fwd_wb_addr;

    integer    seed = 32'h7ea9_895a;
    instr_t    exp_q[$];
    word_t     model_mem [DEPTH_WORDS];
    word_t     next_pc;
    logic      stall_seen;
    logic      cur_rf_wen;
    string     cur_test;
    int        test_errors = 0;
    int        total_errors = 0;
    int        fwd_errors = 0;
    int        fwd_checks = 0;
    int        result_count = 0;
    int        stall_cycles = 0;
    int        cycle_count = 0;

    mem_subsystem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Ends a hung run
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic word_t rand_word();
        word_t r;
        r = $random(seed);
        return r;
    endfunction

    function automatic mem_op_e rand_mem_op();
        word_t r;
        r = rand_word();
        return mem_op_e'({1'b0, r[2:0]} + 4'd1);
    endfunction

    function automatic instr_t bubble_instr();
        instr_t b;
        b         = '0;
        b.pc      = REGPC_NOP;
        b.inst    = INST_NOP;
        b.op      = MEM_NONE;
        return b;
    endfunction

    function automatic instr_t make_instr(input mem_op_e op);
        instr_t t;
        word_t  r;
        r             = rand_word();
        t.pc          = next_pc;
        t.inst        = rand_word();
        t.rs2_data    = rand_word();
        // Memory addresses stay in a 16-word window so loads hit earlier stores
        t.alu_out     = (op == MEM_NONE) ? rand_word() : (rand_word() & 32'h0000_003c);
        t.br_flg      = r[0];
        t.br_target   = rand_word();
        t.op          = op;
        t.rf_wen      = (op == MEM_NONE) ? r[1] : !(op inside {MEM_SB, MEM_SH, MEM_SW});
        t.wb_sel      = r[7:4];
        t.wb_addr     = r[12:8];
        t.jmp_flg     = r[2];
        t.read_data   = '0;
        t.issue_cycle = 0;
        return t;
    endfunction

    // Reference model of memory and load extension in program order
    task automatic model_accept(input instr_t t);
        int    idx;
        word_t w;
        word_t mask;
        idx = int'((t.alu_out >> 2) % DEPTH_WORDS);
        w   = model_mem[idx];
        case (t.op)
            MEM_SB:  mask = 32'h0000_00ff;
            MEM_SH:  mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
        case (t.op)
            MEM_SB, MEM_SH, MEM_SW: model_mem[idx] = (w & ~mask) | (t.rs2_data & mask);
            MEM_LB:  t.read_data = {{24{w[7]}}, w[7:0]};
            MEM_LBU: t.read_data = {24'h0, w[7:0]};
            MEM_LH:  t.read_data = {{16{w[15]}}, w[15:0]};
            MEM_LHU: t.read_data = {16'h0, w[15:0]};
            MEM_LW:  t.read_data = w;
            default: t.read_data = '0;
        endcase
        t.issue_cycle = cycle_count;
        exp_q.push_back(t);
    endtask

    task automatic check_field(input string field, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, field, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        instr_t e;
        if (out_rf_wen || out_pc !== REGPC_NOP) begin
            if (exp_q.size() == 0) begin
                $display("Result at pc %h appeared with no instruction pending", out_pc);
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                result_count++;
                check_field("pc", e.pc, out_pc);
                check_field("inst", e.inst, out_inst);
                check_field("alu_out", e.alu_out, out_alu_out);
                check_field("br_flg", word_t'(e.br_flg), word_t'(out_br_flg));
                check_field("br_target", e.br_target, out_br_target);
                check_field("rf_wen", word_t'(e.rf_wen), word_t'(out_rf_wen));
                check_field("wb_sel", word_t'(e.wb_sel), word_t'(out_wb_sel));
                check_field("wb_addr", word_t'(e.wb_addr), word_t'(out_wb_addr));
                check_field("jmp_flg", word_t'(e.jmp_flg), word_t'(out_jmp_flg));
                if (e.op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW}) begin
                    check_field("read_data", e.read_data, out_read_data);
                end
                if (e.op == MEM_NONE && cycle_count != e.issue_cycle + 1) begin
                    $display("%s: non-memory instruction at pc %h took %0d cycles instead of 1",
                             cur_test, e.pc, cycle_count - e.issue_cycle);
                    test_errors++;
                end
            end
        end else begin
            check_field("bubble inst", INST_NOP, out_inst);
            check_field("bubble br_flg", '0, word_t'(out_br_flg));
            check_field("bubble jmp_flg", '0, word_t'(out_jmp_flg));
        end
    endtask

    task automatic drive(input instr_t t, input logic kill);
        flush        = kill;
        in_pc        = t.pc;
        in_inst      = t.inst;
        in_rs2_data  = t.rs2_data;
        in_alu_out   = t.alu_out;
        in_br_flg    = t.br_flg;
        in_br_target = t.br_target;
        in_mem_op    = t.op;
        in_rf_wen    = t.rf_wen;
        in_wb_sel    = t.wb_sel;
        in_wb_addr   = t.wb_addr;
        in_jmp_flg   = t.jmp_flg;
        cur_rf_wen   = t.rf_wen & ~kill;
    endtask

    // Inputs have settled and stall holds its value for the coming edge
    task automatic settle();
        #1;
        fwd_checks++;
        if (fwd_rf_wen !== cur_rf_wen || fwd_wb_addr !== in_wb_addr) begin
            $display("[FAIL] %s forwarding: expected %b/%0d, actual %b/%0d",
                     cur_test, cur_rf_wen, in_wb_addr, fwd_rf_wen, fwd_wb_addr);
            fwd_errors++;
        end
        stall_seen = stall;
        if (stall) begin
            stall_cycles++;
        end
    endtask

    task automatic issue(input instr_t t, input logic kill);
        @(negedge clk);
        check_outputs();
        while (stall_seen) begin
            settle();
            @(negedge clk);
            check_outputs();
        end
        drive(t, kill);
        if (!kill) begin
            model_accept(t);
        end
        settle();
        if (t.op == MEM_NONE && stall_seen) begin
            $display("Stall was raised for a non-memory instruction at pc %h", t.pc);
            test_errors++;
        end
    endtask

    task automatic issue_op(input mem_op_e op);
        instr_t t;
        t = make_instr(op);
        next_pc += 4;
        issue(t, 1'b0);
    endtask

    task automatic drain();
        while (exp_q.size() > 0) begin
            @(negedge clk);
            check_outputs();
            if (!stall_seen) begin
                drive(bubble_instr(), 1'b0);
            end
            settle();
        end
    endtask

    task automatic finish_test(input int count);
        drain();
        $display("%s: %0d instructions, %0d errors", cur_test, count, test_errors);
        total_errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        instr_t t;
        instr_t u;
        instr_t l;
        word_t  r;
        reset   = 1'b1;
        next_pc = 32'h0000_1000;
        drive(bubble_instr(), 1'b0);
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        settle();

        cur_test = "passthrough";
        repeat (N_PASS) issue_op(MEM_NONE);
        finish_test(N_PASS);

        cur_test = "store_load_word";
        repeat (N_WORD) begin
            r = rand_word();
            issue_op(r[0] ? MEM_SW : MEM_LW);
        end
        finish_test(N_WORD);

        cur_test = "sub_word";
        repeat (N_SUB) issue_op(rand_mem_op());
        finish_test(N_SUB);

        cur_test = "back_to_back";
        stall_cycles = 0;
        repeat (N_B2B) begin
            r = rand_word();
            issue_op((r[1:0] == 2'b00) ? MEM_NONE : rand_mem_op());
        end
        if (stall_cycles == 0) begin
            $display("Stall was never raised during back-to-back memory instructions");
            test_errors++;
        end
        finish_test(N_B2B);

        // Flushed store to the same word must leave the first value in place
        cur_test = "flush";
        for (int i = 0; i < N_FLUSH; i++) begin
            t = make_instr(MEM_SW);
            next_pc += 4;
            issue(t, 1'b0);
            u          = t;
            u.pc       = next_pc;
            u.rs2_data = ~t.rs2_data;
            next_pc += 4;
            issue(u, 1'b1);
            l        = t;
            l.pc     = next_pc;
            l.op     = MEM_LW;
            l.rf_wen = 1'b1;
            next_pc += 4;
            issue(l, 1'b0);
        end
        finish_test(3 * N_FLUSH);

        $display("forwarding: %0d cycles, %0d errors", fwd_checks, fwd_errors);
        $display("Summary: %0d results checked, %0d errors", result_count,
                 total_errors + fwd_errors);
        if (total_errors + fwd_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== logic/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top import mem_pkg::*; #(
    parameter int DEPTH_WORDS  = 256,
    parameter int READ_LATENCY = 2,
    parameter int BUSY_CYCLES  = 1
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,

    input  word_t     in_pc,
    input  word_t     in_inst,
    input  word_t     in_rs2_data,
    input  word_t     in_alu_out,
    input  logic      in_br_flg,
    input  word_t     in_br_target,
    input  mem_op_e   in_mem_op,
    input  logic      in_rf_wen,
    input  wb_sel_t   in_wb_sel,
    input  reg_addr_t in_wb_addr,
    input  logic      in_jmp_flg,

    output word_t     out_read_data,
    output word_t     out_pc,
    output word_t     out_inst,
    output word_t     out_alu_out,
    output logic      out_br_flg,
    output word_t     out_br_target,
    output logic      out_rf_wen,
    output wb_sel_t   out_wb_sel,
    output reg_addr_t out_wb_addr,
    output logic      out_jmp_flg,

    output logic      stall,
    output logic      fwd_rf_wen,
    output reg_addr_t fwd_wb_addr
);

    mem_bus_if bus ();

    mem_access_stage u_stage (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_rs2_data   (in_rs2_data),
        .in_alu_out    (in_alu_out),
        .in_br_flg     (in_br_flg),
        .in_br_target  (in_br_target),
        .in_mem_op     (in_mem_op),
        .in_rf_wen     (in_rf_wen),
        .in_wb_sel     (in_wb_sel),
        .in_wb_addr    (in_wb_addr),
        .in_jmp_flg    (in_jmp_flg),
        .out_read_data (out_read_data),
        .out_pc        (out_pc),
        .out_inst      (out_inst),
        .out_alu_out   (out_alu_out),
        .out_br_flg    (out_br_flg),
        .out_br_target (out_br_target),
        .out_rf_wen    (out_rf_wen),
        .out_wb_sel    (out_wb_sel),
        .out_wb_addr   (out_wb_addr),
        .out_jmp_flg   (out_jmp_flg),
        .stall         (stall),
        .fwd_rf_wen    (fwd_rf_wen),
        .fwd_wb_addr   (fwd_wb_addr),
        .bus           (bus.stage)
    );

    data_memory #(
        .DEPTH_WORDS  (DEPTH_WORDS),
        .READ_LATENCY (READ_LATENCY),
        .BUSY_CYCLES  (BUSY_CYCLES)
    ) u_memory (
        .clk   (clk),
        .reset (reset),
        .bus   (bus.memory)
    );

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import mem_pkg::*; #(
    parameter int DEPTH_WORDS  = 256,
    parameter int READ_LATENCY = 2,
    parameter int BUSY_CYCLES  = 1
) (
    input  logic       clk,
    input  logic       reset,
    mem_bus_if.memory  bus
);

    localparam int IDX_W  = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    localparam int BUSY_W = (BUSY_CYCLES > 0) ? $clog2(BUSY_CYCLES + 1) : 1;
    localparam int LAT_W  = $clog2(READ_LATENCY + 1);

    word_t mem_array [DEPTH_WORDS] = '{default: '0};

    logic [IDX_W-1:0]  word_index;
    logic [BUSY_W-1:0] busy_cnt;
    logic [LAT_W-1:0]  lat_cnt;
    logic              read_pending;
    logic              accept;
    word_t             read_word;

    // Byte address to word index, wrapping at the depth
    assign word_index = IDX_W'((bus.addr >> 2) % DEPTH_WORDS);

    // No new command while busy or while a read is still in flight
    assign bus.cmd_ready = (busy_cnt == '0) && !read_pending;
    assign accept        = bus.cmd_start && bus.cmd_ready;

    assign bus.rdata       = read_word;
    assign bus.rdata_valid = read_pending && (lat_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_cnt <= '0;
        end else if (accept) begin
            busy_cnt <= BUSY_W'(BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // Counts down to the single valid cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            read_pending <= 1'b0;
            lat_cnt      <= '0;
        end else if (accept && !bus.cmd_write) begin
            read_pending <= 1'b1;
            lat_cnt      <= LAT_W'(READ_LATENCY - 1);
        end else if (read_pending) begin
            if (lat_cnt == '0) begin
                read_pending <= 1'b0;
            end else begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (bus.cmd_write) begin
                mem_array[word_index] <= (mem_array[word_index] & ~bus.wmask)
                                       | (bus.wdata & bus.wmask);
            end else begin
                read_word <= mem_array[word_index];
            end
        end
    end

endmodule

// ==== logic/mem_access_stage.sv ====
`timescale 1ns/1ps

module mem_access_stage import mem_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,

    input  word_t     in_pc,
    input  word_t     in_inst,
    input  word_t     in_rs2_data,
    input  word_t     in_alu_out,
    input  logic      in_br_flg,
    input  word_t     in_br_target,
    input  mem_op_e   in_mem_op,
    input  logic      in_rf_wen,
    input  wb_sel_t   in_wb_sel,
    input  reg_addr_t in_wb_addr,
    input  logic      in_jmp_flg,

    output word_t     out_read_data,
    output word_t     out_pc,
    output word_t     out_inst,
    output word_t     out_alu_out,
    output logic      out_br_flg,
    output word_t     out_br_target,
    output logic      out_rf_wen,
    output wb_sel_t   out_wb_sel,
    output reg_addr_t out_wb_addr,
    output logic      out_jmp_flg,

    output logic      stall,
    output logic      fwd_rf_wen,
    output reg_addr_t fwd_wb_addr,

    mem_bus_if.stage  bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_READ
    } state_e;

    state_e state;
    state_e next_state;

    // Live fields, turned into a bubble on flush
    word_t     live_pc;
    word_t     live_inst;
    mem_op_e   live_op;
    logic      live_rf_wen;
    logic      live_br_flg;
    logic      live_jmp_flg;

    // Shadow copy of the held instruction
    word_t     save_pc;
    word_t     save_inst;
    word_t     save_rs2_data;
    word_t     save_alu_out;
    logic      save_br_flg;
    word_t     save_br_target;
    mem_op_e   save_op;
    logic      save_rf_wen;
    wb_sel_t   save_wb_sel;
    reg_addr_t save_wb_addr;
    logic      save_jmp_flg;

    logic  live_load;
    logic  live_store;
    logic  save_store;
    logic  idle;
    logic  take_live;
    logic  take_save;
    word_t load_data;

    assign live_pc      = flush ? REGPC_NOP : in_pc;
    assign live_inst    = flush ? INST_NOP : in_inst;
    assign live_op      = flush ? MEM_NONE : in_mem_op;
    assign live_rf_wen  = flush ? 1'b0 : in_rf_wen;
    assign live_br_flg  = flush ? 1'b0 : in_br_flg;
    assign live_jmp_flg = flush ? 1'b0 : in_jmp_flg;

    assign live_store = live_op inside {MEM_SB, MEM_SH, MEM_SW};
    assign live_load  = live_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    assign save_store = save_op inside {MEM_SB, MEM_SH, MEM_SW};

    assign idle = (state == ST_IDLE);

    // Command comes from the live input when idle, else from the shadow copy
    assign bus.cmd_start = idle ? (live_load | live_store) : (state == ST_WAIT_READY);
    assign bus.cmd_write = idle ? live_store : (state == ST_WAIT_READY) & save_store;
    assign bus.addr      = idle ? in_alu_out : save_alu_out;
    assign bus.wdata     = idle ? in_rs2_data : save_rs2_data;
    assign bus.wmask     = idle ? op_wmask(live_op) : op_wmask(save_op);

    // Retire the live instruction directly, or the held one once memory answers
    assign take_live = idle & (~(live_load | live_store) | (live_store & bus.cmd_ready));
    assign take_save = ((state == ST_WAIT_READY) & save_store & bus.cmd_ready)
                     | ((state == ST_WAIT_READ) & bus.rdata_valid);

    assign stall = ~(take_live | take_save);

    assign fwd_rf_wen  = idle ? live_rf_wen : save_rf_wen;
    assign fwd_wb_addr = idle ? in_wb_addr : save_wb_addr;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (live_store && !bus.cmd_ready) begin
                    next_state = ST_WAIT_READY;
                end else if (live_load) begin
                    next_state = bus.cmd_ready ? ST_WAIT_READ : ST_WAIT_READY;
                end
            end
            ST_WAIT_READY: begin
                if (bus.cmd_ready) begin
                    next_state = save_store ? ST_IDLE : ST_WAIT_READ;
                end
            end
            ST_WAIT_READ: begin
                if (bus.rdata_valid) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
        if (flush) begin
            next_state = ST_IDLE;
        end
    end

    // LH and LB sign-extend, the unsigned forms zero-extend
    always_comb begin
        case (save_op)
            MEM_LB:  load_data = {{24{bus.rdata[7]}}, bus.rdata[7:0]};
            MEM_LBU: load_data = {24'h0, bus.rdata[7:0]};
            MEM_LH:  load_data = {{16{bus.rdata[15]}}, bus.rdata[15:0]};
            MEM_LHU: load_data = {16'h0, bus.rdata[15:0]};
            default: load_data = bus.rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Capture every idle cycle; a flush also overwrites a waiting copy
    always_ff @(posedge clk) begin
        if (idle || flush) begin
            save_pc        <= live_pc;
            save_inst      <= live_inst;
            save_rs2_data  <= in_rs2_data;
            save_alu_out   <= in_alu_out;
            save_br_flg    <= live_br_flg;
            save_br_target <= in_br_target;
            save_op        <= live_op;
            save_rf_wen    <= live_rf_wen;
            save_wb_sel    <= in_wb_sel;
            save_wb_addr   <= in_wb_addr;
            save_jmp_flg   <= live_jmp_flg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_pc      <= REGPC_NOP;
            out_inst    <= INST_NOP;
            out_rf_wen  <= 1'b0;
            out_br_flg  <= 1'b0;
            out_jmp_flg <= 1'b0;
        end else if (take_live) begin
            out_pc      <= live_pc;
            out_inst    <= live_inst;
            out_rf_wen  <= live_rf_wen;
            out_br_flg  <= live_br_flg;
            out_jmp_flg <= live_jmp_flg;
        end else if (take_save) begin
            out_pc      <= save_pc;
            out_inst    <= save_inst;
            out_rf_wen  <= save_rf_wen;
            out_br_flg  <= save_br_flg;
            out_jmp_flg <= save_jmp_flg;
        end else begin
            out_pc      <= REGPC_NOP;
            out_inst    <= INST_NOP;
            out_rf_wen  <= 1'b0;
            out_br_flg  <= 1'b0;
            out_jmp_flg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_live) begin
            out_alu_out   <= in_alu_out;
            out_br_target <= in_br_target;
            out_wb_sel    <= in_wb_sel;
            out_wb_addr   <= in_wb_addr;
        end else if (take_save) begin
            out_alu_out   <= save_alu_out;
            out_br_target <= save_br_target;
            out_wb_sel    <= save_wb_sel;
            out_wb_addr   <= save_wb_addr;
        end else begin
            out_alu_out   <= '1;
            out_br_target <= '1;
            out_wb_sel    <= '0;
            out_wb_addr   <= '0;
        end
        // only a completing load carries data
        out_read_data <= (state == ST_WAIT_READ && bus.rdata_valid) ? load_data : '1;
    end

endmodule

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if import mem_pkg::*; ();

    // Command from the stage
    logic  cmd_start;
    logic  cmd_write;
    word_t addr;
    word_t wdata;
    word_t wmask;

    // Response from the memory
    logic  cmd_ready;
    word_t rdata;
    logic  rdata_valid;

    modport stage (
        output cmd_start,
        output cmd_write,
        output addr,
        output wdata,
        output wmask,
        input  cmd_ready,
        input  rdata,
        input  rdata_valid
    );

    modport memory (
        input  cmd_start,
        input  cmd_write,
        input  addr,
        input  wdata,
        input  wmask,
        output cmd_ready,
        output rdata,
        output rdata_valid
    );

endinterface

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    // 32-bit data, address and PC value
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] reg_addr_t;

    // Write-back source select, not decoded in this stage
    typedef logic [3:0] wb_sel_t;

    // Memory operation carried from execute
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // addi x0, x0, 0
    localparam word_t INST_NOP = 32'h0000_0013;

    // PC value that marks a bubble slot
    localparam word_t REGPC_NOP = 32'hffff_ffff;

    // Bit write mask per operation
    // sub-word stores use the low lanes of the word
    function automatic word_t op_wmask(input mem_op_e op);
        word_t mask;
        case (op)
            MEM_SB:  mask = 32'h0000_00ff;
            MEM_SH:  mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
        return mask;
    endfunction

endpackage
